/* vlog.f */
fp_noncomp_pkg.sv
fp_pipe_stage.sv
fp_classify.sv
fp_sign_inject.sv
fp_compare.sv
fp_noncomp_top.sv
tb_fp_checker.sv
tb_fp_noncomp.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the FP32 unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_fp_noncomp -o tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
  echo "no verdict found in $LOG"
  exit 1
fi
exit 0

/* tb_fp_noncomp.sv */
// --------------------------------------
// Testbench top of the FP32 unit
// Clock, reset, stimulus and reference model
// Per-test report, timeout and verdict
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_fp_noncomp;
  import fp_noncomp_pkg::*;

  localparam int N_SGNJ  = 40;
  localparam int N_MM    = 40;
  localparam int N_CMP   = 48;
  localparam int N_CLASS = 10;
  localparam int N_BP    = 60;
  localparam int N_FLUSH = 14;
  localparam int LIMIT   = (N_SGNJ + N_MM + N_CMP + N_CLASS + N_BP + N_FLUSH) * 4 + 200;

  logic    clk_i;
  logic    rst_n_i;
  logic    flush_i;
  logic    in_valid_i;
  logic    in_ready_o;
  fp_req_t in_req_i;
  logic    out_valid_o;
  logic    out_ready_i;
  fp_rsp_t out_rsp_o;
  logic    busy_o;
  fp_rsp_t exp_rsp;
  int      chk_errors;
  int      chk_rsps;
  int      pending;
  int      tb_errors;
  int      cycles;
  int      ready_mode;
  int      base_err;
  tag_t    next_tag;

  fp_noncomp_top DUT (.*);

  tb_fp_checker u_checker (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_ready_i  (in_ready_o),
    .exp_rsp_i   (exp_rsp),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_rsp_i   (out_rsp_o),
    .busy_i      (busy_o),
    .err_cnt_o   (chk_errors),
    .rsp_cnt_o   (chk_rsps),
    .pending_o   (pending)
  );

  always #2 clk_i = ~clk_i;

  // --------------------------------------
  // Reference model
  // --------------------------------------
  // Ten-way class from the IEEE field rules, RISC-V bit order
  function automatic logic [9:0] class_of(input fp_t x);
    if (x.exponent == 8'h00) begin
      if (x.mantissa == '0) return x.sign ? 10'd8 : 10'd16;
      return x.sign ? 10'd4 : 10'd32;
    end
    if (x.exponent == 8'hff) begin
      if (x.mantissa == '0) return x.sign ? 10'd1 : 10'd128;
      return x.mantissa[MAN_BITS-1] ? 10'd512 : 10'd256;
    end
    return x.sign ? 10'd2 : 10'd64;
  endfunction

  // Strict order on non-NaN values, -0 below +0
  function automatic logic less_than(input fp_t x, input fp_t y);
    if (x.sign != y.sign) return x.sign;
    if (x.sign) return {x.exponent, x.mantissa} > {y.exponent, y.mantissa};
    return {x.exponent, x.mantissa} < {y.exponent, y.mantissa};
  endfunction

  function automatic fp_rsp_t fp_model(input fp_req_t req);
    fp_rsp_t    rsp;
    fp_t        a;
    fp_t        b;
    logic [9:0] ma;
    logic [9:0] mb;
    logic       a_nan;
    logic       b_nan;
    logic       any_snan;
    logic       eq;
    logic       lt;
    logic       flag;
    a        = req.operand_a;
    b        = req.operand_b;
    ma       = class_of(a);
    mb       = class_of(b);
    a_nan    = ma[8] | ma[9];
    b_nan    = mb[8] | mb[9];
    any_snan = ma[8] | mb[8];
    eq       = (req.operand_a == req.operand_b) || ((ma[3] | ma[4]) && (mb[3] | mb[4]));
    lt       = less_than(a, b);
    flag     = 1'b0;
    rsp            = '0;
    rsp.tag        = req.tag;
    rsp.class_mask = fp_classmask_e'(ma);
    case (req.op)
      OP_SGNJ: begin
        rsp.result = req.operand_a;
        if (req.rm == RNE) rsp.result[FP_W-1] = b.sign;
        if (req.rm == RTZ) rsp.result[FP_W-1] = !b.sign;
        if (req.rm == RDN) rsp.result[FP_W-1] = a.sign ^ b.sign;
      end
      OP_MINMAX: begin
        rsp.status.NV = any_snan;
        if (a_nan && b_nan) rsp.result = CANON_QNAN;
        else if (a_nan) rsp.result = req.operand_b;
        else if (b_nan) rsp.result = req.operand_a;
        else if (req.rm == RNE) rsp.result = lt ? req.operand_a : req.operand_b;
        else rsp.result = lt ? req.operand_b : req.operand_a;
      end
      OP_CMP: begin
        if (any_snan || ((a_nan || b_nan) && req.rm != RDN)) begin
          rsp.status.NV = 1'b1;
        end else if (!a_nan && !b_nan) begin
          if (req.rm == RNE) flag = lt | eq;
          else if (req.rm == RTZ) flag = lt & !eq;
          else flag = eq;
          rsp.result[0] = flag ^ req.op_mod;
        end
      end
      default: rsp.is_class = 1'b1;
    endcase
    return rsp;
  endfunction

  always_comb exp_rsp = fp_model(in_req_i);

  // --------------------------------------
  // Stimulus helpers
  // --------------------------------------
  // Special values with some weight, else a random normal
  function automatic fp_word_t pick_operand();
    logic [31:0] r;
    logic [31:0] s;
    r = $urandom;
    s = $urandom;
    case (s % 10)
      0: return {r[31], 31'h0};
      1: return {r[31], 8'hff, 23'h0};
      2: return {r[31], 8'h00, r[22:1], 1'b1};
      3: return {r[31], 8'hff, 1'b1, r[21:0]};
      4: return {r[31], 8'hff, 1'b0, r[21:1], 1'b1};
      5: return {r[31], 31'h3f800000};
      default: return {r[31], (r[30:23] == 8'hff) ? 8'hfe : (r[30:23] | 8'h01), r[22:0]};
    endcase
  endfunction

  // One in four pairs is equal magnitude with flipped sign
  task automatic make_pair(output fp_word_t a, output fp_word_t b);
    logic [31:0] r;
    r = $urandom;
    a = pick_operand();
    b = (r[1:0] == 2'd0) ? {~a[FP_W-1], a[FP_W-2:0]} : pick_operand();
  endtask

  // Called at a falling edge, returns at a falling edge
  task automatic send_op(input fp_op_e op, input fp_rm_e rm, input logic op_mod,
                         input fp_word_t a, input fp_word_t b);
    in_req_i.operand_a = a;
    in_req_i.operand_b = b;
    in_req_i.op        = op;
    in_req_i.rm        = rm;
    in_req_i.op_mod    = op_mod;
    in_req_i.tag       = next_tag;
    in_valid_i         = 1'b1;
    @(posedge clk_i);
    while (!in_ready_o) @(posedge clk_i);
    next_tag = next_tag + 1'b1;
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  task automatic drain();
    while (pending != 0) @(negedge clk_i);
  endtask

  task automatic report_test(input string name, input int ops);
    $display("test %s done: %0d ops, %0d errors", name, ops,
             chk_errors + tb_errors - base_err);
    base_err = chk_errors + tb_errors;
  endtask

  // Output ready: 0 always high, 1 random, 2 held low
  always @(negedge clk_i) begin
    logic [31:0] r;
    r = $urandom;
    out_ready_i = (ready_mode == 0) ? 1'b1 : (ready_mode == 1) ? r[0] : 1'b0;
  end

  // Run limit in cycles
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // --------------------------------------
  // Test sequence
  // --------------------------------------
  initial begin
    fp_word_t    a;
    fp_word_t    b;
    logic [31:0] r;
    fp_word_t    cls[10];
    void'($urandom(32'h1795c2c0));
    cls = '{32'hff800000, 32'hbf800000, 32'h80000001, 32'h80000000, 32'h00000000,
            32'h00400000, 32'h40490fdb, 32'h7f800000, 32'h7f800001, 32'h7fc00000};
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    flush_i = 1'b0;
    in_valid_i = 1'b0;
    in_req_i = '0;
    out_ready_i = 1'b1;
    ready_mode = 0;
    tb_errors = 0;
    base_err = 0;
    cycles = 0;
    next_tag = '0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    if (out_valid_o !== 1'b0 || busy_o !== 1'b0 || in_ready_o !== 1'b1) begin
      $display("error at %0t: outputs not idle after reset", $time);
      tb_errors++;
    end
    report_test("reset", 0);
    // Sign injection, rm cycles through all four
    for (int i = 0; i < N_SGNJ; i++) begin
      make_pair(a, b);
      r = $urandom;
      send_op(OP_SGNJ, (i % 4 == 0) ? RNE : (i % 4 == 1) ? RTZ : (i % 4 == 2) ? RDN : RUP,
              r[0], a, b);
    end
    drain();
    report_test("sign_inject", N_SGNJ);
    // Min/max, directed corner pairs first
    for (int i = 0; i < N_MM; i++) begin
      make_pair(a, b);
      case (i)
        0: begin a = 32'h00000000; b = 32'h80000000; end
        1: begin a = 32'h80000000; b = 32'h00000000; end
        2: begin a = 32'h7fc00000; b = 32'h3f800000; end
        3: begin a = 32'h40000000; b = 32'hffc00001; end
        4: begin a = 32'h7fc00000; b = 32'hffc12345; end
        5: begin a = 32'h7f800001; b = 32'h3f800000; end
        6: begin a = 32'h40400000; b = 32'hff800010; end
        7: begin a = 32'h3fc00000; b = 32'hbfc00000; end
        default: ;
      endcase
      r = $urandom;
      send_op(OP_MINMAX, r[0] ? RTZ : RNE, r[1], a, b);
    end
    drain();
    report_test("min_max", N_MM);
    // Compares, first qNaN then sNaN on each sub-op and op_mod
    for (int i = 0; i < N_CMP; i++) begin
      make_pair(a, b);
      if (i < 6) a = 32'h7fc00000;
      else if (i < 12) b = 32'h7fa00000;
      send_op(OP_CMP, (i % 3 == 0) ? RNE : (i % 3 == 1) ? RTZ : RDN, ((i / 3) % 2) == 1, a, b);
    end
    drain();
    report_test("compare", N_CMP);
    for (int i = 0; i < N_CLASS; i++) begin
      send_op(OP_CLASSIFY, RNE, 1'b0, cls[i], pick_operand());
    end
    drain();
    report_test("classify", N_CLASS);
    // Random mix under random back-pressure
    ready_mode = 1;
    for (int i = 0; i < N_BP; i++) begin
      make_pair(a, b);
      r = $urandom;
      case (r[1:0])
        2'd0: send_op(OP_SGNJ, r[3] ? (r[2] ? RUP : RDN) : (r[2] ? RTZ : RNE), r[4], a, b);
        2'd1: send_op(OP_MINMAX, r[2] ? RTZ : RNE, r[4], a, b);
        2'd2: send_op(OP_CMP, r[3] ? RDN : (r[2] ? RTZ : RNE), r[4], a, b);
        default: send_op(OP_CLASSIFY, RNE, r[4], a, b);
      endcase
    end
    drain();
    ready_mode = 0;
    report_test("backpressure", N_BP);
    // Fill both stages, flush, then normal traffic
    ready_mode = 2;
    @(negedge clk_i);
    send_op(OP_SGNJ, RTZ, 1'b0, 32'h3f800000, 32'h00000000);
    send_op(OP_CMP, RNE, 1'b0, 32'h3f800000, 32'h40000000);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    ready_mode = 0;
    for (int i = 0; i < N_FLUSH - 2; i++) begin
      make_pair(a, b);
      send_op(OP_MINMAX, (i % 2 == 0) ? RNE : RTZ, 1'b0, a, b);
    end
    drain();
    report_test("flush", N_FLUSH);
    $display("summary: 7 tests, %0d responses checked, %0d errors",
             chk_rsps, chk_errors + tb_errors);
    if (chk_errors + tb_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb_fp_checker.sv */
// --------------------------------------
// Response checker of the FP32 unit
// Queue of expected responses per accepted request
// Compare, stall-hold and flush checks, error counts
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_fp_checker
  import fp_noncomp_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    flush_i,
  // Request side of the DUT
  input  logic    in_valid_i,
  input  logic    in_ready_i,
  input  fp_rsp_t exp_rsp_i,
  // Response side of the DUT
  input  logic    out_valid_i,
  input  logic    out_ready_i,
  input  fp_rsp_t out_rsp_i,
  input  logic    busy_i,
  // Counters for the testbench top
  output int      err_cnt_o,
  output int      rsp_cnt_o,
  output int      pending_o
);

  fp_rsp_t exp_q[$];
  fp_rsp_t held_rsp;
  logic    stall_q;
  logic    flush_q;
  int      errors;
  int      responses;
  int      pending;

  initial begin
    errors    = 0;
    responses = 0;
    pending   = 0;
    stall_q   = 1'b0;
    flush_q   = 1'b0;
    held_rsp  = '0;
  end

  assign err_cnt_o = errors;
  assign rsp_cnt_o = responses;
  assign pending_o = pending;

  // --------------------------------------
  // Sampled on the rising edge, DUT state is pre-update here
  // --------------------------------------
  always @(posedge clk_i) begin
    fp_rsp_t exp;
    if (!rst_n_i) begin
      exp_q.delete();
      stall_q = 1'b0;
      flush_q = 1'b0;
    end else begin
      // Both stages empty one edge after a flush
      if (flush_q && (out_valid_i || busy_i)) begin
        $display("error at %0t: out_valid_o or busy_o high after flush", $time);
        errors++;
      end
      // Stalled response must stay put
      if (stall_q && (!out_valid_i || out_rsp_i !== held_rsp)) begin
        $display("error at %0t: stalled response changed or vanished, tag %h",
                 $time, held_rsp.tag);
        errors++;
      end
      // Output handshake, oldest expectation first
      if (out_valid_i && out_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("response with tag %h arrived with no request outstanding at %0t",
                   out_rsp_i.tag, $time);
          errors++;
        end else begin
          exp = exp_q.pop_front();
          responses++;
          if (out_rsp_i !== exp) begin
            // Tag, result, status, class mask and is_class in that order
            $display("error at %0t: exp %h %h %b %b %b, got %h %h %b %b %b",
                     $time, exp.tag, exp.result, exp.status, exp.class_mask, exp.is_class,
                     out_rsp_i.tag, out_rsp_i.result, out_rsp_i.status,
                     out_rsp_i.class_mask, out_rsp_i.is_class);
            errors++;
          end
        end
      end
      // Flush drops everything still in flight
      if (flush_i) begin
        exp_q.delete();
      end else if (in_valid_i && in_ready_i) begin
        exp_q.push_back(exp_rsp_i);
      end
      stall_q  = out_valid_i && !out_ready_i && !flush_i;
      held_rsp = out_rsp_i;
      flush_q  = flush_i;
    end
    pending = exp_q.size();
  end

endmodule

`default_nettype wire

/* fp_noncomp_top.sv */
// --------------------------------------
// FP32 non-computational unit top level
// Input stage, operation blocks, result select
// Output stage, valid/ready on both sides
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module fp_noncomp_top
  import fp_noncomp_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    flush_i,
  // Request side
  input  logic    in_valid_i,
  output logic    in_ready_o,
  input  fp_req_t in_req_i,
  // Response side
  output logic    out_valid_o,
  input  logic    out_ready_i,
  output fp_rsp_t out_rsp_o,
  // Anything in flight
  output logic    busy_o
);

  fp_req_t       req_q;
  logic          req_valid;
  logic          req_ready;
  fp_info_t      info_a;
  fp_info_t      info_b;
  fp_classmask_e class_mask_a;
  fp_word_t      sgnj_result;
  fp_word_t      cmp_result;
  fp_status_t    cmp_status;
  fp_rsp_t       rsp_d;
  logic          rm_legal;

  // --------------------------------------
  // Input stage
  // --------------------------------------
  fp_pipe_stage #(
    .PAYLOAD_W ($bits(fp_req_t))
  ) u_in_stage (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .flush_i    (flush_i),
    .up_valid_i (in_valid_i),
    .up_ready_o (in_ready_o),
    .up_data_i  (in_req_i),
    .dn_valid_o (req_valid),
    .dn_ready_i (req_ready),
    .dn_data_o  (req_q)
  );

  // --------------------------------------
  // Operation blocks
  // --------------------------------------
  fp_classify u_class_a (
    .operand_i    (req_q.operand_a),
    .info_o       (info_a),
    .class_mask_o (class_mask_a)
  );

  // Only the info of b is needed
  fp_classify u_class_b (
    .operand_i    (req_q.operand_b),
    .info_o       (info_b),
    .class_mask_o ()
  );

  fp_sign_inject u_sgnj (
    .operand_a_i (req_q.operand_a),
    .operand_b_i (req_q.operand_b),
    .rm_i        (req_q.rm),
    .result_o    (sgnj_result)
  );

  fp_compare u_cmp (
    .operand_a_i (req_q.operand_a),
    .operand_b_i (req_q.operand_b),
    .info_a_i    (info_a),
    .info_b_i    (info_b),
    .op_i        (req_q.op),
    .rm_i        (req_q.rm),
    .op_mod_i    (req_q.op_mod),
    .result_o    (cmp_result),
    .status_o    (cmp_status)
  );

  // Result select, sign injection and classify raise no flags
  always_comb begin : select_result
    rsp_d            = '0;
    rsp_d.tag        = req_q.tag;
    rsp_d.class_mask = class_mask_a;
    case (req_q.op)
      OP_SGNJ: rsp_d.result = sgnj_result;
      OP_MINMAX, OP_CMP: begin
        rsp_d.result = cmp_result;
        rsp_d.status = cmp_status;
      end
      OP_CLASSIFY: rsp_d.is_class = 1'b1;
      default: rsp_d.result = '0;
    endcase
  end

  // --------------------------------------
  // Output stage
  // --------------------------------------
  fp_pipe_stage #(
    .PAYLOAD_W ($bits(fp_rsp_t))
  ) u_out_stage (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .flush_i    (flush_i),
    .up_valid_i (req_valid),
    .up_ready_o (req_ready),
    .up_data_i  (rsp_d),
    .dn_valid_o (out_valid_o),
    .dn_ready_i (out_ready_i),
    .dn_data_o  (out_rsp_o)
  );

  assign busy_o = req_valid | out_valid_o;

  // Sub-op must be one its group defines
  always_comb begin : rm_check
    case (req_q.op)
      OP_SGNJ:   rm_legal = req_q.rm inside {RNE, RTZ, RDN, RUP};
      OP_MINMAX: rm_legal = req_q.rm inside {RNE, RTZ};
      OP_CMP:    rm_legal = req_q.rm inside {RNE, RTZ, RDN};
      default:   rm_legal = 1'b1;
    endcase
  end

  a_rm_legal: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    req_valid |-> rm_legal
  ) else $error("fp_noncomp_top: undefined rm for op group");

endmodule

`default_nettype wire

/* fp_compare.sv */
// --------------------------------------
// Ordering logic shared by min/max and compares
// NaN-aware MIN/MAX with quiet semantics
// LE/LT signalling, EQ quiet, op_mod inverts
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module fp_compare
  import fp_noncomp_pkg::*;
(
  input  fp_word_t   operand_a_i,
  input  fp_word_t   operand_b_i,
  input  fp_info_t   info_a_i,
  input  fp_info_t   info_b_i,
  input  fp_op_e     op_i,
  input  fp_rm_e     rm_i,
  input  logic       op_mod_i,
  output fp_word_t   result_o,
  output fp_status_t status_o
);

  fp_t      a;
  fp_t      b;
  logic     any_nan;
  logic     any_snan;
  logic     equal;
  logic     a_smaller;
  fp_word_t minmax_res;
  logic     cmp_bool;
  logic     cmp_nv;

  assign a = operand_a_i;
  assign b = operand_b_i;

  // --------------------------------------
  // Shared ordering
  // --------------------------------------
  assign any_nan  = info_a_i.is_nan | info_b_i.is_nan;
  assign any_snan = info_a_i.is_signalling | info_b_i.is_signalling;

  // +0 and -0 count as equal
  assign equal = (operand_a_i == operand_b_i) || (info_a_i.is_zero && info_b_i.is_zero);

  // Sign-magnitude order from an unsigned compare
  // any set sign flips the outcome
  assign a_smaller = (operand_a_i < operand_b_i) ^ (a.sign | b.sign);

  // --------------------------------------
  // Min / max
  // --------------------------------------
  always_comb begin : min_max
    if (info_a_i.is_nan && info_b_i.is_nan) begin
      minmax_res = CANON_QNAN;
    end else if (info_a_i.is_nan) begin
      minmax_res = operand_b_i;
    end else if (info_b_i.is_nan) begin
      minmax_res = operand_a_i;
    end else if (rm_i == RTZ) begin
      // MAX
      minmax_res = a_smaller ? operand_b_i : operand_a_i;
    end else begin
      // MIN
      minmax_res = a_smaller ? operand_a_i : operand_b_i;
    end
  end

  // --------------------------------------
  // Comparisons
  // --------------------------------------
  always_comb begin : comparisons
    cmp_bool = 1'b0;
    cmp_nv   = 1'b0;
    if (any_snan) begin
      // Invalid for every compare
      cmp_nv = 1'b1;
    end else begin
      case (rm_i)
        // LE is a signalling compare
        RNE: begin
          if (any_nan) cmp_nv = 1'b1;
          else cmp_bool = (a_smaller | equal) ^ op_mod_i;
        end
        // LT is a signalling compare too
        RTZ: begin
          if (any_nan) cmp_nv = 1'b1;
          else cmp_bool = (a_smaller & ~equal) ^ op_mod_i;
        end
        // EQ stays quiet on qNaN
        RDN: begin
          if (!any_nan) cmp_bool = equal ^ op_mod_i;
        end
        default: cmp_bool = 1'b0;
      endcase
    end
  end

  // Group select
  always_comb begin : out_sel
    result_o = '0;
    status_o = '0;
    case (op_i)
      OP_MINMAX: begin
        result_o    = minmax_res;
        // Quiet compare, only sNaN is invalid
        status_o.NV = any_snan;
      end
      OP_CMP: begin
        result_o    = {{(FP_W-1){1'b0}}, cmp_bool};
        status_o.NV = cmp_nv;
      end
      default: result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* fp_sign_inject.sv */
// --------------------------------------
// Sign injection
// SGNJ, SGNJN, SGNJX and plain passthrough
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module fp_sign_inject
  import fp_noncomp_pkg::*;
(
  input  fp_word_t operand_a_i,
  input  fp_word_t operand_b_i,
  input  fp_rm_e   rm_i,
  output fp_word_t result_o
);

  fp_t a;
  fp_t b;
  fp_t res;

  assign a = operand_a_i;
  assign b = operand_b_i;

  // Magnitude always comes from a, only the sign moves
  always_comb begin : inject
    res = a;
    case (rm_i)
      // SGNJ
      RNE: res.sign = b.sign;
      // SGNJN
      RTZ: res.sign = ~b.sign;
      // SGNJX
      RDN: res.sign = a.sign ^ b.sign;
      // Passthrough of a
      RUP: res = a;
      default: res = a;
    endcase
  end

  assign result_o = res;

endmodule

`default_nettype wire

/* fp_classify.sv */
// --------------------------------------
// Operand classifier
// Info flags and one-hot class mask of one FP32 word
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module fp_classify
  import fp_noncomp_pkg::*;
(
  input  fp_word_t      operand_i,
  output fp_info_t      info_o,
  output fp_classmask_e class_mask_o
);

  fp_t  op;
  logic exp_zero;
  logic exp_ones;
  logic man_zero;

  assign op       = operand_i;
  assign exp_zero = (op.exponent == '0);
  assign exp_ones = (op.exponent == '1);
  assign man_zero = (op.mantissa == '0);

  // Exponent decides the coarse class, mantissa refines it
  always_comb begin : decode
    info_o               = '0;
    info_o.is_normal     = !exp_zero && !exp_ones;
    info_o.is_subnormal  = exp_zero && !man_zero;
    info_o.is_zero       = exp_zero && man_zero;
    info_o.is_inf        = exp_ones && man_zero;
    info_o.is_nan        = exp_ones && !man_zero;
    // Top mantissa bit is the quiet bit
    info_o.is_signalling = info_o.is_nan && !op.mantissa[MAN_BITS-1];
    info_o.is_quiet      = info_o.is_nan && op.mantissa[MAN_BITS-1];
  end

  // Class mask from class and sign
  always_comb begin : mask
    if (info_o.is_normal) begin
      class_mask_o = op.sign ? NEGNORM : POSNORM;
    end else if (info_o.is_subnormal) begin
      class_mask_o = op.sign ? NEGSUBNORM : POSSUBNORM;
    end else if (info_o.is_zero) begin
      class_mask_o = op.sign ? NEGZERO : POSZERO;
    end else if (info_o.is_inf) begin
      class_mask_o = op.sign ? NEGINF : POSINF;
    end else begin
      // NaN sign is ignored
      class_mask_o = info_o.is_signalling ? SNAN : QNAN;
    end
  end

endmodule

`default_nettype wire

/* fp_pipe_stage.sv */
// --------------------------------------
// Elastic valid/ready register stage
// Width set by PAYLOAD_W, synchronous flush of valid
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module fp_pipe_stage #(
  parameter int unsigned PAYLOAD_W = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 flush_i,
  // Upstream side
  input  logic                 up_valid_i,
  output logic                 up_ready_o,
  input  logic [PAYLOAD_W-1:0] up_data_i,
  // Downstream side
  output logic                 dn_valid_o,
  input  logic                 dn_ready_i,
  output logic [PAYLOAD_W-1:0] dn_data_o
);

  logic                 valid_q;
  logic [PAYLOAD_W-1:0] data_q;
  logic                 accept;

  // Free when the consumer takes our item or we hold a bubble
  assign up_ready_o = dn_ready_i | ~valid_q;
  assign accept     = up_valid_i & up_ready_o;

  // Valid follows upstream whenever the stage advances
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      // Drop whatever is in flight
      valid_q <= 1'b0;
    end else if (up_ready_o) begin
      valid_q <= up_valid_i;
    end
  end

  // Payload only moves on a real transfer
  always_ff @(posedge clk_i) begin
    if (accept) begin
      data_q <= up_data_i;
    end
  end

  assign dn_valid_o = valid_q;
  assign dn_data_o  = data_q;

  // --------------------------------------
  // Checks
  // --------------------------------------
  // A stalled item keeps its data and stays valid until taken
  a_hold_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (dn_valid_o && !dn_ready_i && !flush_i) |=> (dn_valid_o && $stable(dn_data_o))
  ) else $error("fp_pipe_stage: stalled output changed");

endmodule

`default_nettype wire

/* fp_noncomp_pkg.sv */
// --------------------------------------
// Shared definitions of the FP32 non-computational unit
// Format constants and the canonical quiet NaN
// Opcode, sub-op and class mask encodings
// Status and info flag structs
// Request and response structs
// --------------------------------------
`default_nettype none

package fp_noncomp_pkg;

  // --------------------------------------
  // Format
  // --------------------------------------
  localparam int unsigned EXP_BITS = 8;
  localparam int unsigned MAN_BITS = 23;
  localparam int unsigned FP_W     = 32;
  localparam int unsigned TAG_W    = 4;

  // Raw floating-point word
  typedef logic [FP_W-1:0] fp_word_t;

  // Field view of a word
  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp_t;

  // Operation tag, returned unchanged with the result
  typedef logic [TAG_W-1:0] tag_t;

  // Positive sign, all-ones exponent, only the quiet bit set
  localparam fp_word_t CANON_QNAN = {1'b0, {EXP_BITS{1'b1}}, 1'b1, {(MAN_BITS-1){1'b0}}};

  // --------------------------------------
  // Encodings
  // --------------------------------------
  // Operation group
  typedef enum logic [1:0] {
    OP_SGNJ     = 2'd0,
    OP_MINMAX   = 2'd1,
    OP_CMP      = 2'd2,
    OP_CLASSIFY = 2'd3
  } fp_op_e;

  // Sub-op field, carried in the rounding-mode slot
  // SGNJ group uses all four, MINMAX uses RNE/RTZ, CMP uses RNE/RTZ/RDN
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011
  } fp_rm_e;

  // IEEE exception flags
  typedef struct packed {
    logic NV;
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } fp_status_t;

  // One-hot class mask in RISC-V bit order
  typedef enum logic [9:0] {
    NEGINF     = 10'b00_0000_0001,
    NEGNORM    = 10'b00_0000_0010,
    NEGSUBNORM = 10'b00_0000_0100,
    NEGZERO    = 10'b00_0000_1000,
    POSZERO    = 10'b00_0001_0000,
    POSSUBNORM = 10'b00_0010_0000,
    POSNORM    = 10'b00_0100_0000,
    POSINF     = 10'b00_1000_0000,
    SNAN       = 10'b01_0000_0000,
    QNAN       = 10'b10_0000_0000
  } fp_classmask_e;

  // Per-operand decode flags
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
    logic is_quiet;
  } fp_info_t;

  // --------------------------------------
  // Request / response
  // --------------------------------------
  typedef struct packed {
    fp_word_t operand_a;
    fp_word_t operand_b;
    fp_op_e   op;
    fp_rm_e   rm;
    logic     op_mod;
    tag_t     tag;
  } fp_req_t;

  typedef struct packed {
    fp_word_t      result;
    fp_status_t    status;
    fp_classmask_e class_mask;
    logic          is_class;
    tag_t          tag;
  } fp_rsp_t;

endpackage

`default_nettype wire
